//--- logic/x86_pkg.sv
`default_nettype none

package x86_pkg;

   // EIP and GPR width
   localparam int eip_w    = 32;
   // Segment selector
   localparam int seg_w    = 16;
   // MM register, also one cache data word
   localparam int mm_w     = 64;
   localparam int size_w   = 2;
   localparam int reg_id_w = 3;

   // Memory operand size codes
   localparam logic [size_w-1:0] size_8  = 2'd0;
   localparam logic [size_w-1:0] size_16 = 2'd1;
   localparam logic [size_w-1:0] size_32 = 2'd2;
   localparam logic [size_w-1:0] size_64 = 2'd3;

endpackage

`default_nettype wire

//--- logic/ucode_pkg.sv
`default_nettype none

package ucode_pkg;

   // Reduced control word carried with each micro-op
   localparam int ctrl_w = 16;

   // Field positions inside the control word
   // Near return
   localparam int f_near_ret = 0;
   // Far return or IRETD
   localparam int f_far_ret  = 1;
   // JMP or CALL through r/m
   localparam int f_jmp_call = 2;
   // Target taken from an IDT entry
   localparam int f_idt_load = 3;
   // Replace next EIP / next CS
   localparam int f_next_eip = 4;
   localparam int f_next_cs  = 5;
   // B output takes A
   localparam int f_b_from_a = 6;
   // RET imm16, add B[15:0] to the stack pointer
   localparam int f_imm_add  = 7;

   // Select for the upper half of the next EIP
   localparam int neip_hi_sel_w = 2;
   localparam logic [neip_hi_sel_w-1:0] hi_mem_low = 2'd0;
   localparam logic [neip_hi_sel_w-1:0] hi_mem_top = 2'd1;
   localparam logic [neip_hi_sel_w-1:0] hi_reg_a   = 2'd2;
   localparam logic [neip_hi_sel_w-1:0] hi_zero    = 2'd3;

endpackage

`default_nettype wire

//--- logic/mem2_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mem2_decode (
   input  logic [ucode_pkg::ctrl_w-1:0]        ctrl,
   input  logic [x86_pkg::size_w-1:0]          mem_size,
   input  logic                                mem_rd,
   output logic [ucode_pkg::neip_hi_sel_w-1:0] neip_hi_sel,
   output logic                                neip_lo_from_a,
   output logic                                cs_from_top,
   output logic                                mm_a_load
);

   logic near_ret_32;
   logic far_ret_64;
   logic jc_mem;
   logic jc_reg;
   logic idt_load;

   // Near return with a 32-bit pop keeps the full memory EIP
   assign near_ret_32 = ctrl[ucode_pkg::f_near_ret] && (mem_size == x86_pkg::size_32);
   // Far return or IRETD popping EIP and CS together
   assign far_ret_64  = ctrl[ucode_pkg::f_far_ret] && (mem_size == x86_pkg::size_64);

   // JMP/CALL split by operand source
   assign jc_mem   = ctrl[ucode_pkg::f_jmp_call] && mem_rd;
   assign jc_reg   = ctrl[ucode_pkg::f_jmp_call] && !mem_rd;
   assign idt_load = ctrl[ucode_pkg::f_idt_load];

   // Upper EIP half in fixed priority
   always_comb begin
      if (near_ret_32 || far_ret_64 || jc_mem) begin
         neip_hi_sel = ucode_pkg::hi_mem_low;
      end else if (idt_load) begin
         // Gate descriptor splits the offset across bits 63..48 and 15..0
         neip_hi_sel = ucode_pkg::hi_mem_top;
      end else if (jc_reg) begin
         neip_hi_sel = ucode_pkg::hi_reg_a;
      end else begin
         // 16-bit returns zero the top half
         neip_hi_sel = ucode_pkg::hi_zero;
      end
   end

   // Register-form JMP/CALL takes its whole target from A
   assign neip_lo_from_a = jc_reg;

   // CS sits at 47..32 only for the 64-bit far return
   assign cs_from_top = far_ret_64;

   // CALL and IDT load already hold EIP/CS data in MM A
   assign mm_a_load = mem_rd && !ctrl[ucode_pkg::f_jmp_call] && !idt_load;

endmodule

`default_nettype wire

//--- logic/dcache_port.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_port (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   input  logic                     mem_rd,
   input  logic [x86_pkg::eip_w-1:0] mem_rd_addr,
   input  logic [x86_pkg::mm_w-1:0]  dcache_data,
   input  logic                     dcache_ready,
   input  logic                     slot_free,
   output logic                     dcache_en,
   output logic [x86_pkg::eip_w-1:0] dcache_addr,
   output logic [x86_pkg::mm_w-1:0]  load_data,
   output logic                     op_done
);

   logic                    have_data;
   logic [x86_pkg::mm_w-1:0] data_buf;
   logic                    rsp;
   logic                    accept;

   // Request while a read is waiting and nothing is captured yet
   assign dcache_en   = in_valid && mem_rd && !have_data;
   // No TLB so the address goes straight through
   assign dcache_addr = mem_rd_addr;

   // Cache completes the request this cycle
   assign rsp = dcache_en && dcache_ready;

   // Micro-op may leave once it is present and its data is live or buffered
   assign op_done = in_valid && (!mem_rd || have_data || rsp);
   assign accept  = op_done && slot_free;

   // Buffered copy wins once the live cycle has passed
   assign load_data = have_data ? data_buf : dcache_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         have_data <= 1'b0;
      end else if (accept) begin
         have_data <= 1'b0;
      end else if (rsp) begin
         // Output register full so the word is held for later
         have_data <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp) begin
         data_buf <= dcache_data;
      end
   end

   // Request must not move until the cache answers
   a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
      dcache_en && !dcache_ready |=> dcache_en && $stable(dcache_addr));

endmodule

`default_nettype wire

//--- logic/mem2_execute.sv
`timescale 1ns/100ps
`default_nettype none

module mem2_execute (
   input  logic [ucode_pkg::ctrl_w-1:0]        ctrl,
   input  logic [x86_pkg::eip_w-1:0]           neip,
   input  logic [x86_pkg::seg_w-1:0]           ncs,
   input  logic [x86_pkg::eip_w-1:0]           a,
   input  logic [x86_pkg::eip_w-1:0]           b,
   input  logic [x86_pkg::mm_w-1:0]            mm_a,
   input  logic [x86_pkg::eip_w-1:0]           sp_data,
   input  logic                                mem_rd,
   input  logic [x86_pkg::size_w-1:0]          mem_size,
   input  logic [x86_pkg::mm_w-1:0]            load_data,
   input  logic [ucode_pkg::neip_hi_sel_w-1:0] neip_hi_sel,
   input  logic                                neip_lo_from_a,
   input  logic                                cs_from_top,
   input  logic                                mm_a_load,
   output logic [x86_pkg::eip_w-1:0]           nx_eip,
   output logic [x86_pkg::seg_w-1:0]           nx_cs,
   output logic [x86_pkg::eip_w-1:0]           nx_a,
   output logic [x86_pkg::eip_w-1:0]           nx_b,
   output logic [x86_pkg::mm_w-1:0]            nx_mm_a,
   output logic [x86_pkg::eip_w-1:0]           nx_sp
);

   logic [x86_pkg::eip_w-1:0] sext8;
   logic [x86_pkg::eip_w-1:0] sext16;
   logic [x86_pkg::eip_w-1:0] ld_val;
   logic [15:0]               eip_hi;
   logic [15:0]               eip_lo;
   logic [x86_pkg::seg_w-1:0] mem_cs;
   logic [15:0]               imm;

   // Sign extension of narrow loads
   assign sext8  = {{(x86_pkg::eip_w-8){load_data[7]}}, load_data[7:0]};
   assign sext16 = {{(x86_pkg::eip_w-16){load_data[15]}}, load_data[15:0]};

   always_comb begin
      case (mem_size)
         x86_pkg::size_8:  ld_val = sext8;
         x86_pkg::size_16: ld_val = sext16;
         // 32 and 64 both deliver the low word to A
         default:          ld_val = load_data[x86_pkg::eip_w-1:0];
      endcase
   end

   // Upper EIP half
   always_comb begin
      case (neip_hi_sel)
         ucode_pkg::hi_mem_low: eip_hi = load_data[31:16];
         ucode_pkg::hi_mem_top: eip_hi = load_data[63:48];
         ucode_pkg::hi_reg_a:   eip_hi = a[31:16];
         ucode_pkg::hi_zero:    eip_hi = 16'h0000;
      endcase
   end

   // Lower EIP half from A for register jumps, else from memory
   assign eip_lo = neip_lo_from_a ? a[15:0] : load_data[15:0];
   assign nx_eip = ctrl[ucode_pkg::f_next_eip] ? {eip_hi, eip_lo} : neip;

   // CS position depends on far return width
   assign mem_cs = cs_from_top ? load_data[47:32] : load_data[31:16];
   assign nx_cs  = ctrl[ucode_pkg::f_next_cs] ? mem_cs : ncs;

   // Load result replaces A
   assign nx_a    = mem_rd ? ld_val : a;
   assign nx_b    = ctrl[ucode_pkg::f_b_from_a] ? a : b;
   assign nx_mm_a = mm_a_load ? load_data : mm_a;

   // RET imm16 adjusts SP, immediate is unsigned
   assign imm   = ctrl[ucode_pkg::f_imm_add] ? b[15:0] : 16'h0000;
   assign nx_sp = sp_data + {{(x86_pkg::eip_w-16){1'b0}}, imm};

endmodule

`default_nettype wire

//--- logic/mem2_result.sv
`timescale 1ns/100ps
`default_nettype none

module mem2_result (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          take,
   input  logic [x86_pkg::eip_w-1:0]     nx_eip,
   input  logic [x86_pkg::seg_w-1:0]     nx_cs,
   input  logic [x86_pkg::eip_w-1:0]     nx_a,
   input  logic [x86_pkg::eip_w-1:0]     nx_b,
   input  logic [x86_pkg::mm_w-1:0]      nx_mm_a,
   input  logic [x86_pkg::eip_w-1:0]     nx_sp,
   input  logic [x86_pkg::size_w-1:0]    mem_size,
   input  logic [x86_pkg::reg_id_w-1:0]  drid,
   input  logic                          ld_gpr,
   input  logic                          out_ready,
   output logic                          out_valid,
   output logic [x86_pkg::eip_w-1:0]     neip_out,
   output logic [x86_pkg::seg_w-1:0]     ncs_out,
   output logic [x86_pkg::eip_w-1:0]     a_out,
   output logic [x86_pkg::eip_w-1:0]     b_out,
   output logic [x86_pkg::mm_w-1:0]      mm_a_out,
   output logic [x86_pkg::eip_w-1:0]     sp_out,
   output logic [x86_pkg::size_w-1:0]    mem_size_out,
   output logic [x86_pkg::reg_id_w-1:0]  drid_out,
   output logic                          ld_gpr_out,
   output logic                          slot_free
);

   // Room for a new entry when empty or draining this cycle
   assign slot_free = !out_valid || out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // Payload only moves on a new micro-op
   always_ff @(posedge clk) begin
      if (take) begin
         neip_out     <= nx_eip;
         ncs_out      <= nx_cs;
         a_out        <= nx_a;
         b_out        <= nx_b;
         mm_a_out     <= nx_mm_a;
         sp_out       <= nx_sp;
         mem_size_out <= mem_size;
         drid_out     <= drid;
         ld_gpr_out   <= ld_gpr;
      end
   end

   // Stalled result holds until downstream takes it
   a_out_hold : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable({neip_out, ncs_out, a_out, b_out,
         mm_a_out, sp_out, mem_size_out, drid_out, ld_gpr_out}));

endmodule

`default_nettype wire

//--- logic/mem_stage2.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage2 (
   input  logic                          clk,
   input  logic                          rst_n,
   // Upstream micro-op
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [ucode_pkg::ctrl_w-1:0]  ctrl,
   input  logic [x86_pkg::eip_w-1:0]     neip,
   input  logic [x86_pkg::seg_w-1:0]     ncs,
   input  logic [x86_pkg::eip_w-1:0]     a,
   input  logic [x86_pkg::eip_w-1:0]     b,
   input  logic [x86_pkg::mm_w-1:0]      mm_a,
   input  logic [x86_pkg::eip_w-1:0]     sp_data,
   input  logic                          mem_rd,
   input  logic [x86_pkg::eip_w-1:0]     mem_rd_addr,
   input  logic [x86_pkg::size_w-1:0]    mem_size,
   input  logic [x86_pkg::reg_id_w-1:0]  drid,
   input  logic                          ld_gpr,
   // Data cache
   output logic                          dcache_en,
   output logic [x86_pkg::eip_w-1:0]     dcache_addr,
   input  logic [x86_pkg::mm_w-1:0]      dcache_data,
   input  logic                          dcache_ready,
   // Downstream writeback
   output logic                          out_valid,
   input  logic                          out_ready,
   output logic [x86_pkg::eip_w-1:0]     neip_out,
   output logic [x86_pkg::seg_w-1:0]     ncs_out,
   output logic [x86_pkg::eip_w-1:0]     a_out,
   output logic [x86_pkg::eip_w-1:0]     b_out,
   output logic [x86_pkg::mm_w-1:0]      mm_a_out,
   output logic [x86_pkg::eip_w-1:0]     sp_out,
   output logic [x86_pkg::size_w-1:0]    mem_size_out,
   output logic [x86_pkg::reg_id_w-1:0]  drid_out,
   output logic                          ld_gpr_out
);

   logic [ucode_pkg::neip_hi_sel_w-1:0] neip_hi_sel;
   logic                                neip_lo_from_a;
   logic                                cs_from_top;
   logic                                mm_a_load;
   logic [x86_pkg::mm_w-1:0]            load_data;
   logic                                op_done;
   logic                                slot_free;
   logic                                take;
   logic [x86_pkg::eip_w-1:0]           nx_eip;
   logic [x86_pkg::seg_w-1:0]           nx_cs;
   logic [x86_pkg::eip_w-1:0]           nx_a;
   logic [x86_pkg::eip_w-1:0]           nx_b;
   logic [x86_pkg::mm_w-1:0]            nx_mm_a;
   logic [x86_pkg::eip_w-1:0]           nx_sp;

   // Accept when cache work is done and the output slot has room
   assign in_ready = op_done && slot_free;
   assign take     = in_valid && in_ready;

   mem2_decode u_decode (
      .ctrl           (ctrl),
      .mem_size       (mem_size),
      .mem_rd         (mem_rd),
      .neip_hi_sel    (neip_hi_sel),
      .neip_lo_from_a (neip_lo_from_a),
      .cs_from_top    (cs_from_top),
      .mm_a_load      (mm_a_load)
   );

   dcache_port u_dcache_port (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .mem_rd       (mem_rd),
      .mem_rd_addr  (mem_rd_addr),
      .dcache_data  (dcache_data),
      .dcache_ready (dcache_ready),
      .slot_free    (slot_free),
      .dcache_en    (dcache_en),
      .dcache_addr  (dcache_addr),
      .load_data    (load_data),
      .op_done      (op_done)
   );

   mem2_execute u_execute (
      .ctrl           (ctrl),
      .neip           (neip),
      .ncs            (ncs),
      .a              (a),
      .b              (b),
      .mm_a           (mm_a),
      .sp_data        (sp_data),
      .mem_rd         (mem_rd),
      .mem_size       (mem_size),
      .load_data      (load_data),
      .neip_hi_sel    (neip_hi_sel),
      .neip_lo_from_a (neip_lo_from_a),
      .cs_from_top    (cs_from_top),
      .mm_a_load      (mm_a_load),
      .nx_eip         (nx_eip),
      .nx_cs          (nx_cs),
      .nx_a           (nx_a),
      .nx_b           (nx_b),
      .nx_mm_a        (nx_mm_a),
      .nx_sp          (nx_sp)
   );

   // Registered writeback toward the next stage
   mem2_result u_result (
      .clk          (clk),
      .rst_n        (rst_n),
      .take         (take),
      .nx_eip       (nx_eip),
      .nx_cs        (nx_cs),
      .nx_a         (nx_a),
      .nx_b         (nx_b),
      .nx_mm_a      (nx_mm_a),
      .nx_sp        (nx_sp),
      .mem_size     (mem_size),
      .drid         (drid),
      .ld_gpr       (ld_gpr),
      .out_ready    (out_ready),
      .out_valid    (out_valid),
      .neip_out     (neip_out),
      .ncs_out      (ncs_out),
      .a_out        (a_out),
      .b_out        (b_out),
      .mm_a_out     (mm_a_out),
      .sp_out       (sp_out),
      .mem_size_out (mem_size_out),
      .drid_out     (drid_out),
      .ld_gpr_out   (ld_gpr_out),
      .slot_free    (slot_free)
   );

endmodule

`default_nettype wire

//--- verification/mem2_ref.svh
`ifndef MEM2_REF_SVH
`define MEM2_REF_SVH

// One micro-op as the upstream stage presents it
typedef struct packed {
   logic [ucode_pkg::ctrl_w-1:0]   ctrl;
   logic [x86_pkg::eip_w-1:0]      neip;
   logic [x86_pkg::seg_w-1:0]      ncs;
   logic [x86_pkg::eip_w-1:0]      a;
   logic [x86_pkg::eip_w-1:0]      b;
   logic [x86_pkg::mm_w-1:0]       mm_a;
   logic [x86_pkg::eip_w-1:0]      sp_data;
   logic                           mem_rd;
   logic [x86_pkg::eip_w-1:0]      mem_rd_addr;
   logic [x86_pkg::size_w-1:0]     mem_size;
   logic [x86_pkg::reg_id_w-1:0]   drid;
   logic                           ld_gpr;
} op_t;

// Writeback values expected downstream
typedef struct packed {
   logic [x86_pkg::eip_w-1:0]      neip;
   logic [x86_pkg::seg_w-1:0]      ncs;
   logic [x86_pkg::eip_w-1:0]      a;
   logic [x86_pkg::eip_w-1:0]      b;
   logic [x86_pkg::mm_w-1:0]       mm_a;
   logic [x86_pkg::eip_w-1:0]      sp;
   logic [x86_pkg::size_w-1:0]     mem_size;
   logic [x86_pkg::reg_id_w-1:0]   drid;
   logic                           ld_gpr;
} exp_t;

// Expected result of one micro-op, given the cache word it saw
function automatic exp_t mem2_ref(input op_t op, input logic [63:0] word);
   exp_t        r;
   logic        near32;
   logic        far64;
   logic        jc;
   logic        idt;
   logic [31:0] ld;
   logic [15:0] hi;
   logic [15:0] lo;
   near32 = op.ctrl[ucode_pkg::f_near_ret] && (op.mem_size == x86_pkg::size_32);
   far64  = op.ctrl[ucode_pkg::f_far_ret] && (op.mem_size == x86_pkg::size_64);
   jc     = op.ctrl[ucode_pkg::f_jmp_call];
   idt    = op.ctrl[ucode_pkg::f_idt_load];
   // Narrow loads are sign-extended, wide ones give the low word
   case (op.mem_size)
      x86_pkg::size_8:  ld = {{24{word[7]}}, word[7:0]};
      x86_pkg::size_16: ld = {{16{word[15]}}, word[15:0]};
      default:          ld = word[31:0];
   endcase
   // High EIP half by priority
   if (near32 || far64 || (jc && op.mem_rd)) begin
      hi = word[31:16];
   end else if (idt) begin
      hi = word[63:48];
   end else if (jc) begin
      hi = op.a[31:16];
   end else begin
      hi = 16'h0000;
   end
   lo         = (jc && !op.mem_rd) ? op.a[15:0] : word[15:0];
   r.neip     = op.ctrl[ucode_pkg::f_next_eip] ? {hi, lo} : op.neip;
   r.ncs      = !op.ctrl[ucode_pkg::f_next_cs] ? op.ncs : (far64 ? word[47:32] : word[31:16]);
   r.a        = op.mem_rd ? ld : op.a;
   r.b        = op.ctrl[ucode_pkg::f_b_from_a] ? op.a : op.b;
   // CALL and IDT load keep MM A
   r.mm_a     = (op.mem_rd && !jc && !idt) ? word : op.mm_a;
   r.sp       = op.sp_data + (op.ctrl[ucode_pkg::f_imm_add] ? {16'h0000, op.b[15:0]} : 32'h0);
   r.mem_size = op.mem_size;
   r.drid     = op.drid;
   r.ld_gpr   = op.ld_gpr;
   return r;
endfunction

`endif

//--- verification/mem_stage2_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage2_tb;

   `include "mem2_ref.svh"

   localparam int drive_dly  = 2;
   localparam int wait_limit = 200;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   logic        in_ready;
   op_t         cur;
   logic        dcache_en;
   logic [31:0] dcache_addr;
   logic [63:0] dcache_data;
   logic        dcache_ready;
   logic        out_valid;
   logic        out_ready;
   logic [31:0] neip_out;
   logic [15:0] ncs_out;
   logic [31:0] a_out;
   logic [31:0] b_out;
   logic [63:0] mm_a_out;
   logic [31:0] sp_out;
   logic [1:0]  mem_size_out;
   logic [2:0]  drid_out;
   logic        ld_gpr_out;

   exp_t        exp_q[$];
   int          mismatches;
   int          protocol_errs;
   int          timeouts;
   int          checked;
   logic        stalled;
   logic        seen_valid;

   mem_stage2 dut (
      .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .in_ready (in_ready),
      .ctrl (cur.ctrl), .neip (cur.neip), .ncs (cur.ncs), .a (cur.a), .b (cur.b),
      .mm_a (cur.mm_a), .sp_data (cur.sp_data), .mem_rd (cur.mem_rd),
      .mem_rd_addr (cur.mem_rd_addr), .mem_size (cur.mem_size), .drid (cur.drid),
      .ld_gpr (cur.ld_gpr), .dcache_en (dcache_en), .dcache_addr (dcache_addr),
      .dcache_data (dcache_data), .dcache_ready (dcache_ready), .out_valid (out_valid),
      .out_ready (out_ready), .neip_out (neip_out), .ncs_out (ncs_out), .a_out (a_out),
      .b_out (b_out), .mm_a_out (mm_a_out), .sp_out (sp_out),
      .mem_size_out (mem_size_out), .drid_out (drid_out), .ld_gpr_out (ld_gpr_out)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Cache contents where every address bit shows up in the word
   function automatic logic [63:0] cache_word(input logic [31:0] addr);
      return {addr ^ 32'h5a3c_96e1, ~addr};
   endfunction

   // Random micro-op of one kind
   // 0 ALU, 1 load, 2/3 near ret 32/16, 4/5 far ret 32/64, 6 IDT, 7/8 JMP reg/mem, 9 RET imm16
   function automatic op_t make_op(input int kind);
      op_t op;
      op.ctrl        = '0;
      op.neip        = $urandom;
      op.ncs         = 16'($urandom);
      op.a           = $urandom;
      op.b           = $urandom;
      op.mm_a        = {$urandom, $urandom};
      op.sp_data     = $urandom;
      op.mem_rd      = 1'b1;
      op.mem_rd_addr = $urandom;
      op.mem_size    = x86_pkg::size_32;
      op.drid        = 3'($urandom);
      op.ld_gpr      = 1'($urandom);
      op.ctrl[ucode_pkg::f_b_from_a] = 1'($urandom);
      // Control transfers replace EIP and far ones CS too
      op.ctrl[ucode_pkg::f_next_eip] = (kind >= 2);
      op.ctrl[ucode_pkg::f_next_cs]  = (kind >= 4 && kind <= 6);
      case (kind)
         0: op.mem_rd = 1'b0;
         1: op.mem_size = 2'($urandom);
         2: op.ctrl[ucode_pkg::f_near_ret] = 1'b1;
         3: begin
            op.ctrl[ucode_pkg::f_near_ret] = 1'b1;
            op.mem_size = x86_pkg::size_16;
         end
         4: op.ctrl[ucode_pkg::f_far_ret] = 1'b1;
         5: begin
            op.ctrl[ucode_pkg::f_far_ret] = 1'b1;
            op.mem_size = x86_pkg::size_64;
         end
         6: begin
            op.ctrl[ucode_pkg::f_idt_load] = 1'b1;
            op.mem_size = x86_pkg::size_64;
         end
         7: begin
            op.ctrl[ucode_pkg::f_jmp_call] = 1'b1;
            op.mem_rd = 1'b0;
         end
         8: op.ctrl[ucode_pkg::f_jmp_call] = 1'b1;
         default: begin
            op.ctrl[ucode_pkg::f_near_ret] = 1'b1;
            op.ctrl[ucode_pkg::f_imm_add]  = 1'b1;
         end
      endcase
      return op;
   endfunction

   // Present one micro-op and hold it until the stage takes it
   task automatic send_op(input op_t op);
      int   waited;
      logic accepted;
      waited   = 0;
      accepted = 1'b0;
      cur      = op;
      in_valid = 1'b1;
      while (!accepted && waited < wait_limit) begin
         @(negedge clk);
         if (in_ready) begin
            accepted = 1'b1;
         end else begin
            waited++;
         end
      end
      if (accepted) begin
         exp_q.push_back(mem2_ref(op, op.mem_rd ? cache_word(op.mem_rd_addr) : 64'h0));
      end else begin
         timeouts++;
         stalled = 1'b1;
         $display("Timeout at %0t: micro-op was never accepted", $time);
      end
      @(posedge clk);
      #drive_dly;
      in_valid = 1'b0;
   endtask

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] expv);
      assert (got === expv) else begin
         mismatches++;
         $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, expv);
      end
   endtask

   task automatic finish_run();
      $display("Summary: checked=%0d mismatches=%0d protocol=%0d timeouts=%0d",
               checked, mismatches, protocol_errs, timeouts);
      if (mismatches + protocol_errs + timeouts == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   endtask

   // Cache model answering 1 to 4 cycles after the request shows up
   initial begin : cache_model
      int unsigned lat;
      forever begin
         @(negedge clk);
         if (rst_n && dcache_en) begin
            lat = 1 + ($urandom % 4);
            repeat (lat) @(posedge clk);
            #drive_dly;
            dcache_ready = 1'b1;
            dcache_data  = cache_word(dcache_addr);
            @(posedge clk);
            #drive_dly;
            dcache_ready = 1'b0;
            // Junk outside the response cycle
            dcache_data  = {$urandom, $urandom};
         end
      end
   end

   // Random downstream back-pressure
   initial begin : sink_ready
      forever begin
         @(posedge clk);
         #drive_dly;
         out_ready = rst_n && ($urandom % 4 != 0);
      end
   end

   // Request discipline and quiet start after reset
   initial begin : port_watch
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (!seen_valid && !in_valid) begin
               assert (!out_valid && !dcache_en && !in_ready) else begin
                  protocol_errs++;
                  $display("Output, ready or cache request active before any micro-op at %0t",
                           $time);
               end
            end
            assert (!dcache_en || (in_valid && cur.mem_rd)) else begin
               protocol_errs++;
               $display("Cache request without a pending read at %0t", $time);
            end
            // Read address passes through untranslated
            if (dcache_en) begin
               assert (dcache_addr === cur.mem_rd_addr) else begin
                  mismatches++;
                  $display("MISMATCH time=%0t dcache_addr got=%h expected=%h",
                           $time, dcache_addr, cur.mem_rd_addr);
               end
            end
            if (in_valid) begin
               seen_valid = 1'b1;
            end
         end
      end
   end

   // Scoreboard checking that results leave in acceptance order
   initial begin : compare
      exp_t e;
      forever begin
         @(negedge clk);
         if (rst_n && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
               protocol_errs++;
               $display("Output transfer at %0t with no micro-op pending", $time);
            end
            if (exp_q.size() != 0) begin
               e = exp_q.pop_front();
               checked++;
               check_field("neip_out", 64'(neip_out), 64'(e.neip));
               check_field("ncs_out", 64'(ncs_out), 64'(e.ncs));
               check_field("a_out", 64'(a_out), 64'(e.a));
               check_field("b_out", 64'(b_out), 64'(e.b));
               check_field("mm_a_out", mm_a_out, e.mm_a);
               check_field("sp_out", 64'(sp_out), 64'(e.sp));
               check_field("mem_size_out", 64'(mem_size_out), 64'(e.mem_size));
               check_field("drid_out", 64'(drid_out), 64'(e.drid));
               check_field("ld_gpr_out", 64'(ld_gpr_out), 64'(e.ld_gpr));
            end
         end
      end
   end

   initial begin : stimulus
      op_t op;
      int  waited;
      void'($urandom(32'h1ca9_798a));
      mismatches    = 0;
      protocol_errs = 0;
      timeouts      = 0;
      checked       = 0;
      stalled       = 1'b0;
      seen_valid    = 1'b0;
      rst_n         = 1'b0;
      in_valid      = 1'b0;
      cur           = '0;
      dcache_data   = '0;
      dcache_ready  = 1'b0;
      out_ready     = 1'b0;
      repeat (2) @(posedge clk);
      #drive_dly;
      rst_n = 1'b1;
      // Idle cycles to watch the quiet start
      repeat (3) @(posedge clk);
      #drive_dly;
      // Every load size with negative and positive low byte and halfword
      for (int s = 0; s < 4; s++) begin
         for (int j = 0; j < 2; j++) begin
            op             = make_op(1);
            op.mem_size    = 2'(s);
            op.mem_rd_addr = (j == 0) ? 32'h1234_1000 : 32'h0000_8080;
            if (!stalled) send_op(op);
         end
      end
      // Each EIP/CS case twice
      for (int k = 0; k < 20; k++) begin
         if (!stalled) send_op(make_op(k % 10));
      end
      // Random mix with gaps
      for (int i = 0; i < 200; i++) begin
         if (!stalled) begin
            if ($urandom % 5 == 0) begin
               repeat (1 + ($urandom % 2)) @(posedge clk);
               #drive_dly;
            end
            send_op(make_op(int'($urandom % 10)));
         end
      end
      // Drain the output register
      waited = 0;
      while ((exp_q.size() != 0 || out_valid) && waited < wait_limit) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeouts++;
         $display("Timeout: %0d results never came out", exp_q.size());
      end
      finish_run();
   end

endmodule

`default_nettype wire

//--- mem_stage2.f
+incdir+verification
logic/x86_pkg.sv
logic/ucode_pkg.sv
logic/mem2_decode.sv
logic/dcache_port.sv
logic/mem2_execute.sv
logic/mem2_result.sv
logic/mem_stage2.sv
verification/mem_stage2_tb.sv

//--- Makefile
# Verilator build and run of the memory stage 2 testbench

VERILATOR ?= verilator
TOP       ?= mem_stage2_tb
FILELIST  ?= mem_stage2.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verification/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
